//--- rv_branch_pkg.sv
package rv_branch_pkg;

    localparam int XLEN = 32;

    // One report from the branch unit
    typedef struct packed {
        logic issue;
        logic taken;
        logic [XLEN-1:0] pc;
        logic signed [20:0] offset;
    } branch_event_t;

    // Writeback toward the core
    typedef struct packed {
        logic done;
        logic [3:0] id;
        logic [XLEN-1:0] rd;
    } wb_resp_t;

endpackage

//--- prof_types_pkg.sv
package prof_types_pkg;

    localparam int ENTRY_IDX_W = 8;
    localparam int COUNT_MAX_W = 16;

    typedef struct packed {
        logic [rv_branch_pkg::XLEN-1:0] pc;
        logic valid;
        logic [COUNT_MAX_W-1:0] count;
    } prof_entry_t;

    typedef enum logic [1:0] {
        FIELD_BRANCH_ADDR = 2'd0,
        FIELD_ENTRY_VALID = 2'd1,
        FIELD_TAKEN_COUNT = 2'd2
    } prof_field_e;

    typedef struct packed {
        logic op;
        prof_field_e field;
        logic [4:0] pad;
        logic [ENTRY_IDX_W-1:0] index;
    } prof_rd_cmd_t;

    typedef struct packed {
        logic op;
        logic [14:0] pad;
    } prof_lock_cmd_t;

    // Top bit is 0 for a read and 1 for a lock toggle
    typedef union packed {
        prof_rd_cmd_t rd;
        prof_lock_cmd_t lock;
    } prof_cmd_u;

    typedef struct packed {
        logic new_request;
        logic [3:0] id;
        prof_cmd_u cmd;
    } prof_query_t;

    typedef struct packed {
        logic valid;
        logic [ENTRY_IDX_W-1:0] index;
    } tbl_rd_req_t;

endpackage

//--- branch_profiler_table.sv
module branch_profiler_table #(
    parameter int NUM_ENTRIES = 8,
    parameter int COUNT_W = 4,
    parameter int SBB_MAX_OFFSET = -64,
    parameter int TAKEN_THRESHOLD = 12
) (
    input logic clk,
    input logic rst,
    input rv_branch_pkg::branch_event_t branch,
    input logic lock,
    input logic [prof_types_pkg::ENTRY_IDX_W-1:0] rd_index,
    output prof_types_pkg::prof_entry_t rd_entry,
    output logic profiler_exception
);
    import rv_branch_pkg::*;
    import prof_types_pkg::*;

    localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
    localparam logic [COUNT_W:0] THRESH = (COUNT_W + 1)'(TAKEN_THRESHOLD);

    logic [XLEN-1:0] pc_q [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] valid_q;
    logic [COUNT_W-1:0] count_q [NUM_ENTRIES];
    logic [COUNT_W-1:0] next_count [NUM_ENTRIES];

    logic candidate;
    logic sbb;
    logic [NUM_ENTRIES-1:0] match;
    logic [NUM_ENTRIES-1:0] saturated;
    logic halve;
    logic alloc;

    logic any_invalid;
    logic [IDX_W-1:0] first_invalid;
    logic [IDX_W-1:0] min_idx;
    logic [COUNT_W-1:0] min_count;
    logic [IDX_W-1:0] victim;

    logic [NUM_ENTRIES-1:0] thr;
    logic [NUM_ENTRIES-1:0] thr_q;

    assign candidate = branch.issue && branch.taken && !lock;

    // Short backward branch
    assign sbb = ($signed(branch.offset) < 0) && ($signed(branch.offset) > SBB_MAX_OFFSET);

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            match[i] = candidate && valid_q[i] && (pc_q[i] == branch.pc);
            saturated[i] = &count_q[i];
        end
    end

    // A hit on a full counter halves the whole table first
    assign halve = |(match & saturated);

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (halve) begin
                next_count[i] = (count_q[i] >> 1) + COUNT_W'(match[i]);
            end else begin
                next_count[i] = count_q[i] + COUNT_W'(match[i]);
            end
        end
    end

    assign alloc = candidate && sbb && !(|match);

    // Lowest invalid slot
    always_comb begin
        any_invalid = 1'b0;
        first_invalid = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!valid_q[i] && !any_invalid) begin
                any_invalid = 1'b1;
                first_invalid = IDX_W'(i);
            end
        end
    end

    // Smallest count with the lowest index winning ties
    always_comb begin
        min_idx = '0;
        min_count = count_q[0];
        for (int i = 1; i < NUM_ENTRIES; i++) begin
            if (count_q[i] < min_count) begin
                min_count = count_q[i];
                min_idx = IDX_W'(i);
            end
        end
    end

    assign victim = any_invalid ? first_invalid : min_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                pc_q[i] <= '0;
                count_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (alloc && (victim == IDX_W'(i))) begin
                    pc_q[i] <= branch.pc;
                    valid_q[i] <= 1'b1;
                    count_q[i] <= COUNT_W'(1);
                end else begin
                    count_q[i] <= next_count[i];
                end
            end
        end
    end

    // Shared read port
    always_comb begin
        rd_entry = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (rd_index == ENTRY_IDX_W'(i)) begin
                rd_entry.pc = pc_q[i];
                rd_entry.valid = valid_q[i];
                rd_entry.count = COUNT_MAX_W'(count_q[i]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            thr[i] = {1'b0, count_q[i]} >= THRESH;
        end
    end

    // Rising threshold flag that never fires two cycles in a row
    always_ff @(posedge clk) begin
        if (rst) begin
            thr_q <= '0;
            profiler_exception <= 1'b0;
        end else begin
            thr_q <= thr;
            profiler_exception <= (|(thr & ~thr_q)) && !profiler_exception;
        end
    end

endmodule

//--- table_read_arbiter.sv
module table_read_arbiter #(
    parameter int NUM_ENTRIES = 8
) (
    input prof_types_pkg::tbl_rd_req_t cpu_rd,
    input prof_types_pkg::tbl_rd_req_t scan_rd,
    output logic cpu_grant,
    output logic scan_grant,
    output logic [prof_types_pkg::ENTRY_IDX_W-1:0] rd_index
);
    import prof_types_pkg::*;

    logic [ENTRY_IDX_W-1:0] sel_index;
    logic in_range;

    // CPU always wins the port
    assign cpu_grant = cpu_rd.valid;
    assign scan_grant = scan_rd.valid && !cpu_rd.valid;

    assign sel_index = cpu_rd.valid ? cpu_rd.index : scan_rd.index;
    assign in_range = sel_index < NUM_ENTRIES;

    // Out of range falls back to entry 0
    assign rd_index = in_range ? sel_index : '0;

endmodule

//--- profiler_query_unit.sv
module profiler_query_unit #(
    parameter int NUM_ENTRIES = 8
) (
    input logic clk,
    input logic rst,
    input prof_types_pkg::prof_query_t query,
    input logic wb_ack,
    output logic query_ready,
    output rv_branch_pkg::wb_resp_t wb,
    output logic lock,
    output prof_types_pkg::tbl_rd_req_t cpu_rd,
    input prof_types_pkg::prof_entry_t rd_entry
);
    import rv_branch_pkg::*;
    import prof_types_pkg::*;

    logic accept;
    logic is_lock;
    logic waiting;
    logic lock_q;
    logic [3:0] id_q;
    logic [XLEN-1:0] rd_q;

    assign is_lock = query.cmd.lock.op;
    assign accept = query.new_request && !waiting;

    assign cpu_rd.valid = accept && !is_lock;
    assign cpu_rd.index = query.cmd.rd.index;

    // Request sets the flag and wins over a simultaneous ack
    always_ff @(posedge clk) begin
        if (rst) begin
            waiting <= 1'b0;
        end else if (accept) begin
            waiting <= 1'b1;
        end else if (wb_ack) begin
            waiting <= 1'b0;
        end
    end

    // Profiling starts locked
    always_ff @(posedge clk) begin
        if (rst) begin
            lock_q <= 1'b1;
        end else if (accept && is_lock) begin
            lock_q <= !lock_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_q <= '0;
            rd_q <= '0;
        end else if (accept) begin
            id_q <= query.id;
            if (!is_lock) begin
                case (query.cmd.rd.field)
                    FIELD_BRANCH_ADDR: rd_q <= rd_entry.pc;
                    FIELD_ENTRY_VALID: rd_q <= XLEN'(rd_entry.valid);
                    FIELD_TAKEN_COUNT: rd_q <= XLEN'(rd_entry.count);
                    default: rd_q <= rd_q;
                endcase
            end
        end
    end

    assign query_ready = !waiting;
    assign wb = '{done: waiting, id: id_q, rd: rd_q};
    assign lock = lock_q;

endmodule

//--- hot_branch_scanner.sv
module hot_branch_scanner #(
    parameter int NUM_ENTRIES = 8
) (
    input logic clk,
    input logic rst,
    input logic start,
    output prof_types_pkg::tbl_rd_req_t scan_rd,
    input logic scan_grant,
    input prof_types_pkg::prof_entry_t rd_entry,
    output logic hot_valid,
    output logic [prof_types_pkg::ENTRY_IDX_W-1:0] hot_index,
    output logic [rv_branch_pkg::XLEN-1:0] hot_pc
);
    import rv_branch_pkg::*;
    import prof_types_pkg::*;

    localparam logic [ENTRY_IDX_W-1:0] LAST_IDX = ENTRY_IDX_W'(NUM_ENTRIES - 1);

    logic busy;
    logic [ENTRY_IDX_W-1:0] idx_q;
    logic best_found;
    logic [COUNT_MAX_W-1:0] best_count;
    logic [ENTRY_IDX_W-1:0] best_idx;
    logic [XLEN-1:0] best_pc;
    logic better;

    assign scan_rd = '{valid: busy, index: idx_q};

    // Ties keep the first index since only a greater count replaces the best
    assign better = rd_entry.valid && (!best_found || (rd_entry.count > best_count));

    // Walk advances only on granted cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            idx_q <= '0;
            hot_valid <= 1'b0;
        end else begin
            hot_valid <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    idx_q <= '0;
                end
            end else if (scan_grant) begin
                if (idx_q == LAST_IDX) begin
                    busy <= 1'b0;
                    hot_valid <= 1'b1;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    // Best valid entry seen so far
    always_ff @(posedge clk) begin
        if (rst || (start && !busy)) begin
            best_found <= 1'b0;
            best_count <= '0;
            best_idx <= '0;
            best_pc <= '0;
        end else if (busy && scan_grant && better) begin
            best_found <= 1'b1;
            best_count <= rd_entry.count;
            best_idx <= idx_q;
            best_pc <= rd_entry.pc;
        end
    end

    assign hot_index = best_idx;
    assign hot_pc = best_pc;

endmodule

//--- profiler_top.sv
module profiler_top #(
    parameter int NUM_ENTRIES = 8,
    parameter int COUNT_W = 4,
    parameter int SBB_MAX_OFFSET = -64,
    parameter int TAKEN_THRESHOLD = 12
) (
    input logic clk,
    input logic rst,
    input rv_branch_pkg::branch_event_t branch,
    input prof_types_pkg::prof_query_t query,
    input logic wb_ack,
    output logic query_ready,
    output rv_branch_pkg::wb_resp_t wb,
    output logic profiler_exception,
    output logic hot_valid,
    output logic [prof_types_pkg::ENTRY_IDX_W-1:0] hot_index,
    output logic [rv_branch_pkg::XLEN-1:0] hot_pc
);
    import prof_types_pkg::*;

    logic lock;
    tbl_rd_req_t cpu_rd;
    tbl_rd_req_t scan_rd;
    logic scan_grant;
    logic [ENTRY_IDX_W-1:0] rd_index;
    prof_entry_t rd_entry;

    branch_profiler_table #(
        .NUM_ENTRIES(NUM_ENTRIES),
        .COUNT_W(COUNT_W),
        .SBB_MAX_OFFSET(SBB_MAX_OFFSET),
        .TAKEN_THRESHOLD(TAKEN_THRESHOLD)
    ) u_table (
        .clk(clk),
        .rst(rst),
        .branch(branch),
        .lock(lock),
        .rd_index(rd_index),
        .rd_entry(rd_entry),
        .profiler_exception(profiler_exception)
    );

    // Query unit has fixed priority and needs no grant back
    table_read_arbiter #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_arb (
        .cpu_rd(cpu_rd),
        .scan_rd(scan_rd),
        .cpu_grant(),
        .scan_grant(scan_grant),
        .rd_index(rd_index)
    );

    profiler_query_unit #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_query (
        .clk(clk),
        .rst(rst),
        .query(query),
        .wb_ack(wb_ack),
        .query_ready(query_ready),
        .wb(wb),
        .lock(lock),
        .cpu_rd(cpu_rd),
        .rd_entry(rd_entry)
    );

    hot_branch_scanner #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_scan (
        .clk(clk),
        .rst(rst),
        .start(profiler_exception),
        .scan_rd(scan_rd),
        .scan_grant(scan_grant),
        .rd_entry(rd_entry),
        .hot_valid(hot_valid),
        .hot_index(hot_index),
        .hot_pc(hot_pc)
    );

endmodule

//--- profiler_checker.sv
module profiler_checker (
    input logic clk,
    input logic rst,
    input logic query_ready,
    input rv_branch_pkg::wb_resp_t wb,
    input logic profiler_exception,
    input logic hot_valid,
    input logic [prof_types_pkg::ENTRY_IDX_W-1:0] hot_index,
    input logic [rv_branch_pkg::XLEN-1:0] hot_pc,
    input logic exp_done,
    input logic [3:0] exp_id,
    input logic [rv_branch_pkg::XLEN-1:0] exp_rd,
    input logic exp_exc,
    input logic [prof_types_pkg::ENTRY_IDX_W-1:0] exp_hot_index,
    input logic [rv_branch_pkg::XLEN-1:0] exp_hot_pc,
    output int errors,
    output logic scan_pending
);
    logic exc_prev;

    initial begin
        errors = 0;
        scan_pending = 1'b0;
        exc_prev = 1'b0;
    end

    // Sample away from the rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (wb.done !== exp_done) begin
                $display("[ERROR] %0t: wb.done got %b expected %b", $time, wb.done, exp_done);
                errors++;
            end
            if (query_ready !== !exp_done) begin
                $display("[ERROR] %0t: query_ready got %b", $time, query_ready);
                errors++;
            end
            if (wb.id !== exp_id || wb.rd !== exp_rd) begin
                $display("[ERROR] %0t: wb id/rd got %h/%h expected %h/%h",
                         $time, wb.id, wb.rd, exp_id, exp_rd);
                errors++;
            end
            if (profiler_exception !== exp_exc) begin
                $display("[ERROR] %0t: exception got %b expected %b",
                         $time, profiler_exception, exp_exc);
                errors++;
            end
            if (profiler_exception && exc_prev) begin
                $display("[ERROR] %0t: exception high two cycles in a row", $time);
                errors++;
            end
            if (hot_valid) begin
                if (!scan_pending) begin
                    $display("[ERROR] %0t: hot_valid without a preceding exception", $time);
                    errors++;
                end else if (hot_index !== exp_hot_index || hot_pc !== exp_hot_pc) begin
                    $display("[ERROR] %0t: hot report got %0d/%h expected %0d/%h",
                             $time, hot_index, hot_pc, exp_hot_index, exp_hot_pc);
                    errors++;
                end
                scan_pending = 1'b0;
            end
            if (exp_exc) begin
                scan_pending = 1'b1;
            end
            exc_prev = profiler_exception;
        end
    end

endmodule

//--- tb_profiler.sv
module tb_profiler;
    import rv_branch_pkg::*;
    import prof_types_pkg::*;

    localparam int NE = 8;
    localparam int THRESHOLD = 12;
    localparam int STIM_CYCLES = 3000;

    logic clk;
    logic rst;
    branch_event_t branch;
    prof_query_t query;
    logic wb_ack;
    logic query_ready;
    wb_resp_t wb;
    logic profiler_exception;
    logic hot_valid;
    logic [ENTRY_IDX_W-1:0] hot_index;
    logic [XLEN-1:0] hot_pc;

    integer seed = 32'h0f7f_a09c;
    int errors;
    logic scan_pending;
    int cycles = 0;
    int scans = 0;
    logic hold = 1'b0;
    logic [XLEN-1:0] pc_pool [12];
    logic signed [20:0] off_pool [12];

    // Reference model state
    logic [XLEN-1:0] m_pc [NE];
    logic [NE-1:0] m_valid;
    logic [3:0] m_count [NE];
    logic [NE-1:0] m_thr_q;
    logic m_exc, m_lock, m_waiting;
    logic [3:0] m_id;
    logic [XLEN-1:0] m_rd;
    logic [ENTRY_IDX_W-1:0] m_hot_idx;
    logic [XLEN-1:0] m_hot_pc;

    profiler_top uut (
        .clk(clk), .rst(rst), .branch(branch), .query(query), .wb_ack(wb_ack),
        .query_ready(query_ready), .wb(wb), .profiler_exception(profiler_exception),
        .hot_valid(hot_valid), .hot_index(hot_index), .hot_pc(hot_pc)
    );

    profiler_checker chk (
        .clk(clk), .rst(rst), .query_ready(query_ready), .wb(wb),
        .profiler_exception(profiler_exception), .hot_valid(hot_valid),
        .hot_index(hot_index), .hot_pc(hot_pc), .exp_done(m_waiting), .exp_id(m_id),
        .exp_rd(m_rd), .exp_exc(m_exc), .exp_hot_index(m_hot_idx), .exp_hot_pc(m_hot_pc),
        .errors(errors), .scan_pending(scan_pending)
    );

    always #10 clk = ~clk;

    task automatic reset_model();
        for (int i = 0; i < NE; i++) begin
            m_pc[i] = '0;
            m_count[i] = '0;
        end
        m_valid = '0;
        m_thr_q = '0;
        m_exc = 1'b0;
        m_lock = 1'b1;
        m_waiting = 1'b0;
        m_id = '0;
        m_rd = '0;
        m_hot_idx = '0;
        m_hot_pc = '0;
    endtask

    task automatic step_model();
        logic [NE-1:0] thr;
        logic old_lock;
        logic accept;
        int idx;
        int hit;
        int victim;
        for (int i = 0; i < NE; i++) begin
            thr[i] = m_count[i] >= THRESHOLD;
        end
        m_exc = (|(thr & ~m_thr_q)) && !m_exc;
        m_thr_q = thr;
        if (m_exc) begin
            scans++;
        end
        // Reads see the table before this edge's update
        old_lock = m_lock;
        accept = query.new_request && !m_waiting;
        if (accept) begin
            m_id = query.id;
            if (query.cmd.lock.op) begin
                m_lock = !m_lock;
            end else begin
                idx = (query.cmd.rd.index < NE) ? query.cmd.rd.index : 0;
                if (query.cmd.rd.field == FIELD_BRANCH_ADDR) m_rd = m_pc[idx];
                else if (query.cmd.rd.field == FIELD_ENTRY_VALID) m_rd = m_valid[idx];
                else if (query.cmd.rd.field == FIELD_TAKEN_COUNT) m_rd = m_count[idx];
            end
        end
        m_waiting = accept ? 1'b1 : (wb_ack ? 1'b0 : m_waiting);
        if (branch.issue && branch.taken && !old_lock) begin
            hit = -1;
            for (int i = 0; i < NE; i++) begin
                if (m_valid[i] && m_pc[i] == branch.pc) hit = i;
            end
            if (hit >= 0) begin
                if (m_count[hit] == 4'hf) begin
                    for (int i = 0; i < NE; i++) m_count[i] = m_count[i] >> 1;
                end
                m_count[hit] = m_count[hit] + 1;
            end else if (branch.offset < 0 && branch.offset > -64) begin
                victim = -1;
                for (int i = 0; i < NE; i++) begin
                    if (!m_valid[i] && victim < 0) victim = i;
                end
                if (victim < 0) begin
                    victim = 0;
                    for (int i = 1; i < NE; i++) begin
                        if (m_count[i] < m_count[victim]) victim = i;
                    end
                end
                m_pc[victim] = branch.pc;
                m_valid[victim] = 1'b1;
                m_count[victim] = 4'd1;
            end
        end
        // Hottest valid entry with the first index winning ties
        m_hot_idx = '0;
        m_hot_pc = '0;
        hit = -1;
        for (int i = 0; i < NE; i++) begin
            if (m_valid[i] && (hit < 0 || m_count[i] > m_count[hit])) begin
                hit = i;
                m_hot_idx = i;
                m_hot_pc = m_pc[i];
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) reset_model();
        else step_model();
    end

    task automatic drive_cycle(input logic allow_lock, input logic allow_branch);
        int r;
        int sel;
        @(posedge clk);
        #2;
        if (m_exc) hold = 1'b1;
        if (hot_valid) hold = 1'b0;
        r = $random(seed);
        sel = r[4] ? (r[7:5] % 3) : (r[15:8] % 12);
        branch.issue = allow_branch && !hold && (r[17:16] != 0);
        branch.taken = r[19:18] != 0;
        branch.pc = pc_pool[sel];
        branch.offset = off_pool[sel];
        wb_ack = r[21:20] == 0;
        query = '0;
        if (!m_waiting && r[23:22] != 0) begin
            query.new_request = 1'b1;
            query.id = r[27:24];
            if (allow_lock && r[31:27] == 0) begin
                query.cmd.lock.op = 1'b1;
            end else begin
                query.cmd.rd.field = prof_field_e'(r[29:28]);
                query.cmd.rd.index = r[15:8] % 10;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > 4000 + 20 * scans) begin
            $display("Timeout: run did not finish within the cycle limit");
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        branch = '0;
        query = '0;
        wb_ack = 1'b0;
        for (int i = 0; i < 12; i++) begin
            pc_pool[i] = 32'h0000_2000 + i * 32'h124;
            off_pool[i] = (i < 10) ? -(4 + 6 * i) : ((i == 10) ? -21'sd300 : 21'sd48);
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        // Branches while locked must leave the table empty
        repeat (60) drive_cycle(1'b0, 1'b1);
        // Quiet the query port and drain the last writeback
        @(posedge clk);
        #2;
        branch = '0;
        query = '0;
        wb_ack = 1'b1;
        while (m_waiting) begin
            @(posedge clk);
            #2;
        end
        query.new_request = 1'b1;
        query.cmd.lock.op = 1'b1;
        repeat (STIM_CYCLES) drive_cycle(1'b1, 1'b1);
        repeat (40) drive_cycle(1'b0, 1'b0);
        @(negedge clk);
        #1;
        if (scan_pending) begin
            $display("Hot-branch scan never reported after an exception");
        end
        $display("errors: %0d", errors);
        if (errors == 0 && !scan_pending) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
rv_branch_pkg.sv
prof_types_pkg.sv
branch_profiler_table.sv
table_read_arbiter.sv
profiler_query_unit.sv
hot_branch_scanner.sv
profiler_top.sv
profiler_checker.sv
tb_profiler.sv

//--- Bender.yml
package:
  name: branch_profiler

sources:
  - rv_branch_pkg.sv
  - prof_types_pkg.sv
  - branch_profiler_table.sv
  - table_read_arbiter.sv
  - profiler_query_unit.sv
  - hot_branch_scanner.sv
  - profiler_top.sv
  - target: simulation
    files:
      - profiler_checker.sv
      - tb_profiler.sv
